// ==== vlog.f ====
+incdir+hdl
hdl/ebusPkg.sv
hdl/iEBUS.sv
hdl/ebusDiagDecode.sv
hdl/aprDevice.sv
hdl/piDevice.sv
hdl/ebusMux.sv
hdl/ebusTop.sv
testbench/ebusTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ebusTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== testbench/ebusTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_config.svh"

module ebusTb;
  import ebusPkg::*;

  localparam int NumRows     = 17;
  localparam int ReadTimeout = 10;

  // one console request per row
  // rows with rnd set take a random write word instead of wdata
  typedef struct packed {
    tEbusDev                dev;
    tDiagFunc               func;
    tEbusWord               wdata;
    logic [0:`APR_ERRORS-1] err;
    logic [1:`PI_LEVELS]    pi;
    logic                   rnd;
  } tRow;

  logic                   clk;
  logic                   rst;
  logic                   diagReq;
  tEbusDev                diagDev;
  tDiagFunc               diagFunc;
  tEbusWord               writeData;
  logic [0:`APR_ERRORS-1] errorIn;
  logic [1:`PI_LEVELS]    piReq;
  tEbusWord               readData;
  logic                   readValid;
  logic [2:0]             piLevel;
  logic                   piActive;

  // reference copies of the device state
  logic [0:`APR_ERRORS-1] mFlags;
  logic [0:`APR_ERRORS-1] mMask;
  logic [1:`PI_LEVELS]    mPend;
  logic [1:`PI_LEVELS]    mEn;
  tEbusWord               lastRead;
  integer                 seed;

  tRow rows [NumRows] = '{
    '{DEV_APR,  FN_READ,  36'h0,  4'b0000, 7'b0000000, 1'b0},
    '{DEV_PI,   FN_READ,  36'h0,  4'b0000, 7'b0000000, 1'b0},
    '{DEV_NONE, FN_READ,  36'h0,  4'b0000, 7'b0000000, 1'b0},
    '{DEV_APR,  FN_READ,  36'h0,  4'b1010, 7'b0000000, 1'b0},
    '{DEV_APR,  FN_READ,  36'h0,  4'b0101, 7'b0000000, 1'b0},
    '{DEV_APR,  FN_CLEAR, 36'h0,  4'b0000, 7'b0000000, 1'b0},
    '{DEV_APR,  FN_WRITE, 36'h4,  4'b0000, 7'b0000000, 1'b0},
    '{DEV_APR,  FN_READ,  36'h0,  4'b0001, 7'b0000000, 1'b0},
    '{DEV_PI,   FN_WRITE, 36'h10, 4'b0000, 7'b0000000, 1'b0},
    '{DEV_APR,  FN_READ,  36'h0,  4'b0100, 7'b0000000, 1'b0},
    '{DEV_APR,  FN_CLEAR, 36'h0,  4'b0000, 7'b0000000, 1'b0},
    '{DEV_PI,   FN_CLEAR, 36'h0,  4'b0000, 7'b0000000, 1'b0},
    '{DEV_PI,   FN_WRITE, 36'h0,  4'b0000, 7'b0001010, 1'b1},
    '{DEV_PI,   FN_READ,  36'h0,  4'b0000, 7'b0100100, 1'b0},
    '{DEV_PI,   FN_WRITE, 36'h0,  4'b0000, 7'b1000001, 1'b1},
    '{DEV_PI,   FN_CLEAR, 36'h0,  4'b0000, 7'b0000000, 1'b0},
    '{DEV_PI,   FN_READ,  36'h0,  4'b0000, 7'b0000000, 1'b0}
  };

  always #4 clk = ~clk;

  ebusTop DUT (
    .clk       (clk),
    .rst       (rst),
    .diagReq   (diagReq),
    .diagDev   (diagDev),
    .diagFunc  (diagFunc),
    .writeData (writeData),
    .errorIn   (errorIn),
    .piReq     (piReq),
    .readData  (readData),
    .readValid (readValid),
    .piLevel   (piLevel),
    .piActive  (piActive)
  );

  function automatic logic aprIntModel();
    return |(mFlags & mMask);
  endfunction

  // level 1 has the highest priority
  function automatic logic [2:0] levelModel();
    logic [2:0] lvl;
    lvl = 3'd0;
    for (int i = 1; i <= `PI_LEVELS; i++) begin
      if (lvl == 3'd0 && mPend[i] && mEn[i]) begin
        lvl = 3'(i);
      end
    end
    return lvl;
  endfunction

  function automatic tEbusWord expectedWord(input tEbusDev dev);
    tEbusWord w;
    w = '0;
    if (dev == DEV_APR) begin
      w[28:31] = mFlags;
      w[32:35] = mMask;
    end else if (dev == DEV_PI) begin
      w[19:21] = levelModel();
      w[22:28] = mEn;
      w[29:35] = mPend;
    end
    return w;
  endfunction

  task automatic abortRun();
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkWord(input tEbusWord got, input tEbusWord exp, input int row);
    if (got !== exp) begin
      $display("[ERROR] %0t: row %0d readData %h, expected %h", $time, row, got, exp);
      abortRun();
    end
  endtask

  task automatic checkLevel(input logic [2:0] gotLevel, input logic gotActive,
                            input logic [2:0] expLevel, input logic expActive,
                            input int row);
    if (gotLevel !== expLevel || gotActive !== expActive) begin
      $display("[ERROR] %0t: row %0d piLevel %0d piActive %b, expected %0d %b",
               $time, row, gotLevel, gotActive, expLevel, expActive);
      abortRun();
    end
  endtask

  // models the clock edge that ends the strobe cycle and lands writes and clears
  task automatic strobeEdge(input tEbusDev dev, input tDiagFunc func, input tEbusWord wdata);
    logic aprInt;
    aprInt = aprIntModel();
    if (dev == DEV_PI && func == FN_CLEAR) begin
      mPend = '0;
    end else if (aprInt) begin
      mPend[`APR_PI_LEVEL] = 1'b1;
    end
    if (dev == DEV_APR && func == FN_CLEAR) begin
      mFlags = '0;
    end
    if (dev == DEV_APR && func == FN_WRITE) begin
      mMask = wdata[32:35];
    end
    if (dev == DEV_PI && func == FN_WRITE) begin
      mEn = wdata[29:35];
    end
    // the APR request goes on setting its level on the following edges
    if (aprIntModel()) begin
      mPend[`APR_PI_LEVEL] = 1'b1;
    end
  endtask

  task automatic applyRow(input int r);
    tEbusWord    wdata;
    tEbusWord    expWord;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [2:0]  expLevel;
    int          waited;
    wdata = rows[r].wdata;
    if (rows[r].rnd) begin
      hi    = $random(seed);
      lo    = $random(seed);
      wdata = {hi[3:0], lo};
    end
    @(posedge clk);
    #1;
    diagReq   = 1'b1;
    diagDev   = rows[r].dev;
    diagFunc  = rows[r].func;
    writeData = wdata;
    errorIn   = rows[r].err;
    piReq     = rows[r].pi;
    @(posedge clk);
    #1;
    diagReq  = 1'b0;
    diagDev  = DEV_NONE;
    diagFunc = FN_IDLE;
    errorIn  = '0;
    piReq    = '0;
    // errors and requests were taken on the edge that registered the request
    if (aprIntModel()) begin
      mPend[`APR_PI_LEVEL] = 1'b1;
    end
    mPend   = mPend | rows[r].pi;
    mFlags  = mFlags | rows[r].err;
    expWord = expectedWord(rows[r].dev);
    strobeEdge(rows[r].dev, rows[r].func, wdata);
    if (rows[r].func == FN_READ) begin
      waited = 0;
      @(negedge clk);
      while (!readValid && waited < ReadTimeout) begin
        waited++;
        @(negedge clk);
      end
      if (!readValid) begin
        $display("timeout: no readValid came for the read in row %0d", r);
        abortRun();
      end
      checkWord(readData, expWord, r);
      lastRead = expWord;
      @(negedge clk);
      if (readValid) begin
        $display("readValid stayed high for more than one cycle in row %0d", r);
        abortRun();
      end
    end else begin
      for (int c = 0; c < 4; c++) begin
        @(negedge clk);
        if (readValid) begin
          $display("readValid pulsed for a write or clear in row %0d", r);
          abortRun();
        end
      end
      checkWord(readData, lastRead, r);
    end
    @(negedge clk);
    expLevel = levelModel();
    checkLevel(piLevel, piActive, expLevel, expLevel != 3'd0, r);
  endtask

  initial begin
    seed       = 32'h4ec6883c;
    clk        = 1'b0;
    rst        = 1'b1;
    diagReq    = 1'b0;
    diagDev    = DEV_NONE;
    diagFunc   = FN_IDLE;
    writeData  = '0;
    errorIn    = '0;
    piReq      = '0;
    mFlags     = '0;
    mMask      = '0;
    mPend      = '0;
    mEn        = '0;
    lastRead   = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int r = 0; r < NumRows; r++) begin
      applyRow(r);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/ebusTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_config.svh"

// diagnostic EBUS subsystem with the APR and PI devices
module ebusTop (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   diagReq,
  input  ebusPkg::tEbusDev       diagDev,
  input  ebusPkg::tDiagFunc      diagFunc,
  input  ebusPkg::tEbusWord      writeData,
  input  logic [0:`APR_ERRORS-1] errorIn,
  input  logic [1:`PI_LEVELS]    piReq,
  output ebusPkg::tEbusWord      readData,
  output logic                   readValid,
  output logic [2:0]             piLevel,
  output logic                   piActive
);
  import ebusPkg::*;

  iEBUS ebus ();

  // one driver record per device, merged in the multiplexer
  tEBUSdriver aprDrv;
  tEBUSdriver piDrv;
  logic       aprIntReq;

  ebusDiagDecode decode0 (
    .clk       (clk),
    .rst       (rst),
    .diagReq   (diagReq),
    .diagDev   (diagDev),
    .diagFunc  (diagFunc),
    .writeData (writeData),
    .bus       (ebus.ctl)
  );

  aprDevice apr0 (
    .clk       (clk),
    .rst       (rst),
    .errorIn   (errorIn),
    .bus       (ebus.dev),
    .drv       (aprDrv),
    .aprIntReq (aprIntReq)
  );

  piDevice pi0 (
    .clk       (clk),
    .rst       (rst),
    .piReq     (piReq),
    .aprIntReq (aprIntReq),
    .bus       (ebus.dev),
    .drv       (piDrv),
    .piLevel   (piLevel),
    .piActive  (piActive)
  );

  ebusMux mux0 (
    .clk       (clk),
    .rst       (rst),
    .aprDrv    (aprDrv),
    .piDrv     (piDrv),
    .bus       (ebus.mux),
    .readData  (readData),
    .readValid (readValid)
  );

endmodule

`default_nettype wire

// ==== hdl/ebusMux.sv ====
`timescale 1ns/1ps
`default_nettype none

// output side of the EBUS
// device records are collapsed onto the shared word by fixed priority,
// and every diagnostic read is captured for the console
module ebusMux (
  input  logic                clk,
  input  logic                rst,
  input  ebusPkg::tEBUSdriver aprDrv,
  input  ebusPkg::tEBUSdriver piDrv,
  iEBUS.mux                   bus,
  output ebusPkg::tEbusWord   readData,
  output logic                readValid
);
  import ebusPkg::*;

  tEbusWord ebusData;
  logic     readStrobe;

  // APR first, then PI, and an undriven bus reads as zero
  always_comb begin
    if (aprDrv.driving) begin
      ebusData = aprDrv.data;
    end else if (piDrv.driving) begin
      ebusData = piDrv.data;
    end else begin
      ebusData = '0;
    end
  end

  assign bus.data   = ebusData;
  assign readStrobe = bus.strobe && (bus.func == FN_READ);

  // readData keeps the last word read until the next read replaces it
  always_ff @(posedge clk) begin
    if (rst) begin
      readData  <= '0;
      readValid <= 1'b0;
    end else begin
      readValid <= readStrobe;
      if (readStrobe) begin
        readData <= ebusData;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    !(aprDrv.driving && piDrv.driving))
    else $error("APR and PI drive the EBUS at the same time");

  // a read addressed to a real device must find that device on the bus
  assert property (@(posedge clk) disable iff (rst)
    (readStrobe && bus.cs != DEV_NONE) |-> (aprDrv.driving || piDrv.driving))
    else $error("EBUS read left undriven by the selected device");

endmodule

`default_nettype wire

// ==== hdl/piDevice.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_config.svh"

// priority interrupt device
// requests on levels 1 to 7 are latched as pending and the highest
// priority level that is both pending and enabled is reported
module piDevice (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [1:`PI_LEVELS]  piReq,
  input  logic                 aprIntReq,
  iEBUS.dev                    bus,
  output ebusPkg::tEBUSdriver  drv,
  output logic [2:0]           piLevel,
  output logic                 piActive
);
  import ebusPkg::*;

  // the status word is packed against the low end of the word
  localparam int PendPos  = `EBUS_WIDTH - `PI_LEVELS;
  localparam int EnPos    = PendPos - `PI_LEVELS;
  localparam int LevelPos = EnPos - 3;

  logic [1:`PI_LEVELS] pending;
  logic [1:`PI_LEVELS] enable;
  logic [1:`PI_LEVELS] aprLevelReq;
  logic [1:`PI_LEVELS] reqIn;
  logic [1:`PI_LEVELS] live;
  logic                selected;
  logic                clearSel;
  tEbusWord            statusWord;

  assign selected = bus.strobe && (bus.cs == DEV_PI);
  assign clearSel = selected && (bus.func == FN_CLEAR);

  // the APR has a fixed slot among the request lines
  always_comb begin
    aprLevelReq = '0;
    aprLevelReq[`APR_PI_LEVEL] = aprIntReq;
  end

  assign reqIn = piReq | aprLevelReq;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
      enable  <= '0;
    end else begin
      if (clearSel) begin
        pending <= '0;
      end else begin
        pending <= pending | reqIn;
      end

      if (selected && bus.func == FN_WRITE) begin
        enable <= bus.wrData[PendPos +: `PI_LEVELS];
      end
    end
  end

  assign live = pending & enable;

  // scan from the lowest priority upward so the lowest number wins
  always_comb begin
    piLevel = 3'd0;
    for (int i = `PI_LEVELS; i >= 1; i--) begin
      if (live[i]) begin
        piLevel = 3'(i);
      end
    end
  end

  assign piActive = |live;

  always_comb begin
    statusWord = '0;
    statusWord[LevelPos +: 3]         = piLevel;
    statusWord[EnPos +: `PI_LEVELS]   = enable;
    statusWord[PendPos +: `PI_LEVELS] = pending;
  end

  assign drv.driving = selected && (bus.func == FN_READ);
  assign drv.data    = drv.driving ? statusWord : '0;

endmodule

`default_nettype wire

// ==== hdl/aprDevice.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_config.svh"

// APR status device
// error flags are sticky until the console clears them,
// and any flag under an enabled mask bit asks the PI for service
module aprDevice (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [0:`APR_ERRORS-1] errorIn,
  iEBUS.dev                     bus,
  output ebusPkg::tEBUSdriver   drv,
  output logic                  aprIntReq
);
  import ebusPkg::*;

  // flags sit just above the mask in the status word
  localparam int MaskPos = `EBUS_WIDTH - `APR_ERRORS;
  localparam int FlagPos = MaskPos - `APR_ERRORS;

  logic [0:`APR_ERRORS-1] errFlags;
  logic [0:`APR_ERRORS-1] enMask;
  logic                   selected;
  tEbusWord               statusWord;

  assign selected = bus.strobe && (bus.cs == DEV_APR);

  always_ff @(posedge clk) begin
    if (rst) begin
      errFlags <= '0;
      enMask   <= '0;
    end else begin
      // a clear wins over an error arriving in the same cycle
      if (selected && bus.func == FN_CLEAR) begin
        errFlags <= '0;
      end else begin
        errFlags <= errFlags | errorIn;
      end

      if (selected && bus.func == FN_WRITE) begin
        enMask <= bus.wrData[MaskPos +: `APR_ERRORS];
      end
    end
  end

  always_comb begin
    statusWord = '0;
    statusWord[FlagPos +: `APR_ERRORS] = errFlags;
    statusWord[MaskPos +: `APR_ERRORS] = enMask;
  end

  // the record is only valid while this device is being read
  assign drv.driving = selected && (bus.func == FN_READ);
  assign drv.data    = drv.driving ? statusWord : '0;

  assign aprIntReq = |(errFlags & enMask);

endmodule

`default_nettype wire

// ==== hdl/ebusDiagDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

// console side of the diagnostic path
// a one-cycle request from the console is captured and shows up on the
// EBUS in the following cycle together with a single strobe
module ebusDiagDecode (
  input  logic              clk,
  input  logic              rst,
  input  logic              diagReq,
  input  ebusPkg::tEbusDev  diagDev,
  input  ebusPkg::tDiagFunc diagFunc,
  input  ebusPkg::tEbusWord writeData,
  iEBUS.ctl                 bus
);
  import ebusPkg::*;

  // select and function only live for the strobe cycle
  // between requests the bus falls back to no device and no function
  always_ff @(posedge clk) begin
    if (rst) begin
      bus.cs     <= DEV_NONE;
      bus.func   <= FN_IDLE;
      bus.strobe <= 1'b0;
    end else if (diagReq) begin
      bus.cs     <= diagDev;
      bus.func   <= diagFunc;
      bus.strobe <= 1'b1;
    end else begin
      bus.cs     <= DEV_NONE;
      bus.func   <= FN_IDLE;
      bus.strobe <= 1'b0;
    end
  end

  // the write word is taken with the request and is only looked at
  // by the devices while strobe is up
  always_ff @(posedge clk) begin
    if (diagReq) begin
      bus.wrData <= writeData;
    end
  end

  // requests are at least two cycles apart, so a strobe is never stretched
  // and every device sees each function exactly once
  assert property (@(posedge clk) disable iff (rst)
    bus.strobe |=> !bus.strobe)
    else $error("EBUS strobe held for more than one cycle");

endmodule

`default_nettype wire

// ==== hdl/iEBUS.sv ====
`timescale 1ns/1ps
`default_nettype none

// the EBUS as seen inside the subsystem
// the decoder owns select, function, strobe and write data,
// and the multiplexer owns the shared data word
interface iEBUS;
  import ebusPkg::*;

  tEbusDev  cs;
  tDiagFunc func;
  logic     strobe;
  tEbusWord wrData;
  tEbusWord data;

  modport ctl (
    output cs,
    output func,
    output strobe,
    output wrData
  );

  modport dev (
    input cs,
    input func,
    input strobe,
    input wrData
  );

  modport mux (
    output data,
    input  strobe,
    input  func,
    input  cs
  );

endinterface

`default_nettype wire

// ==== hdl/ebusPkg.sv ====
`default_nettype none

`include "ebus_config.svh"

// types shared by every block that sits on the diagnostic EBUS
package ebusPkg;

  // a full EBUS word in the usual 0-to-35 big-endian numbering
  typedef logic [0:`EBUS_WIDTH-1] tEbusWord;

  // what each device hands to the EBUS multiplexer
  // a device only owns the bus while driving is set
  typedef struct packed {
    logic     driving;
    tEbusWord data;
  } tEBUSdriver;

  // device select codes as issued by the console
  typedef enum logic [1:0] {
    DEV_NONE = 2'd0,
    DEV_APR  = 2'd1,
    DEV_PI   = 2'd2
  } tEbusDev;

  // diagnostic functions
  // FN_READ asks the selected device for its status word,
  // FN_WRITE loads it from the write data and FN_CLEAR drops its sticky state
  typedef enum logic [1:0] {
    FN_IDLE  = 2'd0,
    FN_READ  = 2'd1,
    FN_WRITE = 2'd2,
    FN_CLEAR = 2'd3
  } tDiagFunc;

endpackage

`default_nettype wire

// ==== hdl/ebus_config.svh ====
`ifndef EBUS_CONFIG_SVH
`define EBUS_CONFIG_SVH

// sizing of the diagnostic EBUS subsystem

// EBUS word, numbered 0 to 35 with bit 0 as the most significant
`define EBUS_WIDTH 36

// priority interrupt levels, numbered 1 to 7 with 1 as the highest priority
`define PI_LEVELS 7

// fixed PI level on which the APR asks for service
`define APR_PI_LEVEL 3

// number of sticky APR error flags
`define APR_ERRORS 4

`endif
